// ==== source/mips_isa_pkg.sv ====
package mips_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;

  localparam int imem_words = 256;
  typedef logic [$clog2(imem_words)-1:0] imem_addr_t;

  localparam opcode_t op_special = 6'h00;
  localparam opcode_t op_regimm  = 6'h01;
  localparam opcode_t op_j       = 6'h02;
  localparam opcode_t op_jal     = 6'h03;
  localparam opcode_t op_beq     = 6'h04;
  localparam opcode_t op_bne     = 6'h05;
  localparam opcode_t op_blez    = 6'h06;
  localparam opcode_t op_bgtz    = 6'h07;
  localparam opcode_t op_addi    = 6'h08;
  localparam opcode_t op_addiu   = 6'h09;
  localparam opcode_t op_slti    = 6'h0a;
  localparam opcode_t op_sltiu   = 6'h0b;
  localparam opcode_t op_andi    = 6'h0c;
  localparam opcode_t op_ori     = 6'h0d;
  localparam opcode_t op_xori    = 6'h0e;
  localparam opcode_t op_lui     = 6'h0f;

  // rt field of the regimm group
  localparam reg_idx_t regimm_bltz = 5'h00;
  localparam reg_idx_t regimm_bgez = 5'h01;

  localparam reg_idx_t reg_ra = 5'd31;  // jal link target

  localparam funct_t funct_sll  = 6'd0;
  localparam funct_t funct_srl  = 6'd2;
  localparam funct_t funct_sra  = 6'd3;
  localparam funct_t funct_sllv = 6'd4;
  localparam funct_t funct_srlv = 6'd6;
  localparam funct_t funct_srav = 6'd7;
  localparam funct_t funct_jr   = 6'd8;
  localparam funct_t funct_jalr = 6'd9;
  localparam funct_t funct_add  = 6'd32;
  localparam funct_t funct_addu = 6'd33;
  localparam funct_t funct_sub  = 6'd34;
  localparam funct_t funct_subu = 6'd35;
  localparam funct_t funct_and  = 6'd36;
  localparam funct_t funct_or   = 6'd37;
  localparam funct_t funct_xor  = 6'd38;
  localparam funct_t funct_nor  = 6'd39;
  localparam funct_t funct_slt  = 6'd42;
  localparam funct_t funct_sltu = 6'd43;

endpackage

// ==== source/core_cfg_pkg.sv ====
package core_cfg_pkg;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_e;

  typedef enum logic [3:0] {
    br_none, br_eq, br_ne, br_lez, br_gtz, br_ltz, br_gez, br_jump, br_jump_reg
  } br_kind_e;

  typedef struct packed {
    alu_op_e                alu_op;
    logic                   src_imm;     // operand b from immediate
    logic                   imm_signed;
    logic                   shamt_var;   // shift amount from rs
    logic                   wr_en;
    mips_isa_pkg::reg_idx_t wr_reg;
    logic                   link;        // write pc + 4
    br_kind_e               br_kind;
    logic                   illegal;
  } ctrl_t;

  typedef struct packed {
    mips_isa_pkg::word_t    pc;
    mips_isa_pkg::word_t    inst;
    logic                   wr_en;
    mips_isa_pkg::reg_idx_t wr_reg;
    mips_isa_pkg::word_t    wr_data;
  } retire_t;

endpackage

// ==== source/text_idec.sv ====
`timescale 1ns/1ps

module text_idec (
  input  mips_isa_pkg::word_t inst_word,
  input  mips_isa_pkg::word_t pc,
  output string               inst_str
);

  mips_isa_pkg::opcode_t  opc;
  mips_isa_pkg::reg_idx_t rs;
  mips_isa_pkg::reg_idx_t rt;
  mips_isa_pkg::reg_idx_t rd;
  mips_isa_pkg::imm_t     imm;
  mips_isa_pkg::funct_t   funct;
  logic [4:0]             shamt;
  mips_isa_pkg::word_t    pc_plus_4;
  mips_isa_pkg::word_t    jmp_addr;

  assign opc       = inst_word[31:26];
  assign rs        = inst_word[25:21];
  assign rt        = inst_word[20:16];
  assign rd        = inst_word[15:11];
  assign shamt     = inst_word[10:6];
  assign funct     = inst_word[5:0];
  assign imm       = inst_word[15:0];
  assign pc_plus_4 = pc + 32'd4;
  assign jmp_addr  = {pc_plus_4[31:28], inst_word[25:0], 2'b00};

  always_comb begin
    case (opc)
      mips_isa_pkg::op_special: begin
        case (funct)
          mips_isa_pkg::funct_sll:  $sformat(inst_str, "sll $%0d, $%0d, %0d", rd, rt, shamt);
          mips_isa_pkg::funct_srl:  $sformat(inst_str, "srl $%0d, $%0d, %0d", rd, rt, shamt);
          mips_isa_pkg::funct_sra:  $sformat(inst_str, "sra $%0d, $%0d, %0d", rd, rt, shamt);
          mips_isa_pkg::funct_sllv: $sformat(inst_str, "sllv $%0d, $%0d, $%0d", rd, rt, rs);
          mips_isa_pkg::funct_srlv: $sformat(inst_str, "srlv $%0d, $%0d, $%0d", rd, rt, rs);
          mips_isa_pkg::funct_srav: $sformat(inst_str, "srav $%0d, $%0d, $%0d", rd, rt, rs);
          mips_isa_pkg::funct_jr:   $sformat(inst_str, "jr $%0d", rs);
          mips_isa_pkg::funct_jalr: $sformat(inst_str, "jalr $%0d, $%0d", rs, rd);
          6'd16: $sformat(inst_str, "mfhi $%0d", rd);
          6'd17: $sformat(inst_str, "mthi $%0d", rs);
          6'd18: $sformat(inst_str, "mflo $%0d", rd);
          6'd19: $sformat(inst_str, "mtlo $%0d", rs);
          6'd24: $sformat(inst_str, "mult $%0d, $%0d", rs, rt);
          6'd25: $sformat(inst_str, "multu $%0d, $%0d", rs, rt);
          6'd26: $sformat(inst_str, "div $%0d, $%0d", rs, rt);
          6'd27: $sformat(inst_str, "divu $%0d, $%0d", rs, rt);
          mips_isa_pkg::funct_add:  $sformat(inst_str, "add $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_addu: $sformat(inst_str, "addu $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_sub:  $sformat(inst_str, "sub $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_subu: $sformat(inst_str, "subu $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_and:  $sformat(inst_str, "and $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_or:   $sformat(inst_str, "or $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_xor:  $sformat(inst_str, "xor $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_nor:  $sformat(inst_str, "nor $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_slt:  $sformat(inst_str, "slt $%0d, $%0d, $%0d", rd, rs, rt);
          mips_isa_pkg::funct_sltu: $sformat(inst_str, "sltu $%0d, $%0d, $%0d", rd, rs, rt);
          default: begin
            $sformat(inst_str, "Unknown instruction: opc: %x, funct: %0d", opc, funct);
          end
        endcase
      end
      mips_isa_pkg::op_regimm: begin
        case (rt)
          mips_isa_pkg::regimm_bltz: $sformat(inst_str, "bltz $%0d, 0x%x", rs, imm);
          mips_isa_pkg::regimm_bgez: $sformat(inst_str, "bgez $%0d, 0x%x", rs, imm);
          5'h10: $sformat(inst_str, "bltzal $%0d, 0x%x", rs, imm);
          5'h11: $sformat(inst_str, "bgezal $%0d, 0x%x", rs, imm);
          default: begin
            $sformat(inst_str, "Unknown instruction: opc: %x, rt: %0d", opc, rt);
          end
        endcase
      end
      mips_isa_pkg::op_j:     $sformat(inst_str, "j 0x%x", jmp_addr);
      mips_isa_pkg::op_jal:   $sformat(inst_str, "jal 0x%x", jmp_addr);
      mips_isa_pkg::op_beq:   $sformat(inst_str, "beq $%0d, $%0d, 0x%x", rs, rt, imm);
      mips_isa_pkg::op_bne:   $sformat(inst_str, "bne $%0d, $%0d, 0x%x", rs, rt, imm);
      mips_isa_pkg::op_blez:  $sformat(inst_str, "blez $%0d, 0x%x", rs, imm);
      mips_isa_pkg::op_bgtz:  $sformat(inst_str, "bgtz $%0d, 0x%x", rs, imm);
      mips_isa_pkg::op_addi:  $sformat(inst_str, "addi $%0d, $%0d, 0x%x", rt, rs, imm);
      mips_isa_pkg::op_addiu: $sformat(inst_str, "addiu $%0d, $%0d, 0x%x", rt, rs, imm);
      mips_isa_pkg::op_slti:  $sformat(inst_str, "slti $%0d, $%0d, 0x%x", rt, rs, imm);
      mips_isa_pkg::op_sltiu: $sformat(inst_str, "sltiu $%0d, $%0d, 0x%x", rt, rs, imm);
      mips_isa_pkg::op_andi:  $sformat(inst_str, "andi $%0d, $%0d, 0x%x", rt, rs, imm);
      mips_isa_pkg::op_ori:   $sformat(inst_str, "ori $%0d, $%0d, 0x%x", rt, rs, imm);
      mips_isa_pkg::op_xori:  $sformat(inst_str, "xori $%0d, $%0d, 0x%x", rt, rs, imm);
      mips_isa_pkg::op_lui:   $sformat(inst_str, "lui $%0d, 0x%x", rt, imm);
      // memory ops, printed but not executed by the core
      6'h20: $sformat(inst_str, "lb, $%0d, ($%0d + ...0x%x)", rt, rs, imm);
      6'h21: $sformat(inst_str, "lh, $%0d, ($%0d + ...0x%x)", rt, rs, imm);
      6'h23: $sformat(inst_str, "lw, $%0d, ($%0d + ...0x%x)", rt, rs, imm);
      6'h24: $sformat(inst_str, "lbu, $%0d, ($%0d + ...0x%x)", rt, rs, imm);
      6'h25: $sformat(inst_str, "lhu, $%0d, ($%0d + ...0x%x)", rt, rs, imm);
      6'h28: $sformat(inst_str, "sb, $%0d, ($%0d + ...0x%x)", rt, rs, imm);
      6'h29: $sformat(inst_str, "sh, $%0d, ($%0d + ...0x%x)", rt, rs, imm);
      6'h2b: $sformat(inst_str, "sw, $%0d, ($%0d + ...0x%x)", rt, rs, imm);
      default: $sformat(inst_str, "Unknown instruction: opc: %x", opc);
    endcase
  end

endmodule

// ==== source/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     run,
  input  logic                     imem_we,
  input  mips_isa_pkg::imem_addr_t imem_addr,
  input  mips_isa_pkg::word_t      imem_data,
  input  core_cfg_pkg::ctrl_t      ctrl,
  input  logic                     taken,
  input  mips_isa_pkg::word_t      rs_val,
  input  mips_isa_pkg::imm_t       imm,
  output mips_isa_pkg::word_t      pc,
  output mips_isa_pkg::word_t      inst
);

  mips_isa_pkg::word_t mem [mips_isa_pkg::imem_words];
  mips_isa_pkg::word_t pc_plus_4;
  mips_isa_pkg::word_t br_target;
  mips_isa_pkg::word_t next_pc;

  assign inst      = mem[pc[9:2]];  // pc wraps inside the memory
  assign pc_plus_4 = pc + 32'd4;
  assign br_target = pc_plus_4 + {{14{imm[15]}}, imm, 2'b00};

  always_comb begin
    next_pc = pc_plus_4;
    if (taken) begin
      case (ctrl.br_kind)
        core_cfg_pkg::br_jump:     next_pc = {pc_plus_4[31:28], inst[25:0], 2'b00};
        core_cfg_pkg::br_jump_reg: next_pc = rs_val;
        default:                   next_pc = br_target;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (imem_we) begin
      mem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (run) begin
      pc <= next_pc;
    end
  end

  // program load only while the core is halted
  a_load_halted: assert property (@(posedge clk) disable iff (rst) !(imem_we && run));

endmodule

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
  input  mips_isa_pkg::word_t    inst,
  output core_cfg_pkg::ctrl_t    ctrl,
  output mips_isa_pkg::reg_idx_t rs,
  output mips_isa_pkg::reg_idx_t rt,
  output mips_isa_pkg::imm_t     imm,
  output logic [4:0]             shamt
);

  mips_isa_pkg::opcode_t  opcode;
  mips_isa_pkg::funct_t   funct;
  mips_isa_pkg::reg_idx_t rd;

  assign opcode = inst[31:26];
  assign rs     = inst[25:21];
  assign rt     = inst[20:16];
  assign rd     = inst[15:11];
  assign shamt  = inst[10:6];
  assign funct  = inst[5:0];
  assign imm    = inst[15:0];

  always_comb begin
    ctrl.alu_op     = core_cfg_pkg::alu_add;
    ctrl.src_imm    = 1'b1;  // I-type defaults
    ctrl.imm_signed = 1'b1;
    ctrl.shamt_var  = 1'b0;
    ctrl.wr_en      = 1'b1;
    ctrl.wr_reg     = rt;
    ctrl.link       = 1'b0;
    ctrl.br_kind    = core_cfg_pkg::br_none;
    ctrl.illegal    = 1'b0;
    case (opcode)
      mips_isa_pkg::op_special: begin
        ctrl.src_imm = 1'b0;
        ctrl.wr_reg  = rd;
        ctrl.shamt_var = funct[2];  // sllv, srlv, srav
        case (funct)
          mips_isa_pkg::funct_sll, mips_isa_pkg::funct_sllv: ctrl.alu_op = core_cfg_pkg::alu_sll;
          mips_isa_pkg::funct_srl, mips_isa_pkg::funct_srlv: ctrl.alu_op = core_cfg_pkg::alu_srl;
          mips_isa_pkg::funct_sra, mips_isa_pkg::funct_srav: ctrl.alu_op = core_cfg_pkg::alu_sra;
          mips_isa_pkg::funct_jr: begin
            ctrl.br_kind = core_cfg_pkg::br_jump_reg;
            ctrl.wr_en   = 1'b0;
          end
          mips_isa_pkg::funct_jalr: begin
            ctrl.br_kind = core_cfg_pkg::br_jump_reg;
            ctrl.link    = 1'b1;
          end
          mips_isa_pkg::funct_add, mips_isa_pkg::funct_addu: ctrl.alu_op = core_cfg_pkg::alu_add;
          mips_isa_pkg::funct_sub, mips_isa_pkg::funct_subu: ctrl.alu_op = core_cfg_pkg::alu_sub;
          mips_isa_pkg::funct_and:  ctrl.alu_op = core_cfg_pkg::alu_and;
          mips_isa_pkg::funct_or:   ctrl.alu_op = core_cfg_pkg::alu_or;
          mips_isa_pkg::funct_xor:  ctrl.alu_op = core_cfg_pkg::alu_xor;
          mips_isa_pkg::funct_nor:  ctrl.alu_op = core_cfg_pkg::alu_nor;
          mips_isa_pkg::funct_slt:  ctrl.alu_op = core_cfg_pkg::alu_slt;
          mips_isa_pkg::funct_sltu: ctrl.alu_op = core_cfg_pkg::alu_sltu;
          default:                  ctrl.illegal = 1'b1;
        endcase
      end
      mips_isa_pkg::op_regimm: begin
        ctrl.src_imm = 1'b0;
        ctrl.wr_en   = 1'b0;
        case (rt)
          mips_isa_pkg::regimm_bltz: ctrl.br_kind = core_cfg_pkg::br_ltz;
          mips_isa_pkg::regimm_bgez: ctrl.br_kind = core_cfg_pkg::br_gez;
          default:                   ctrl.illegal = 1'b1;  // -al forms too
        endcase
      end
      mips_isa_pkg::op_j: begin
        ctrl.br_kind = core_cfg_pkg::br_jump;
        ctrl.wr_en   = 1'b0;
      end
      mips_isa_pkg::op_jal: begin
        ctrl.br_kind = core_cfg_pkg::br_jump;
        ctrl.wr_reg  = mips_isa_pkg::reg_ra;
        ctrl.link    = 1'b1;
      end
      mips_isa_pkg::op_beq, mips_isa_pkg::op_bne, mips_isa_pkg::op_blez,
      mips_isa_pkg::op_bgtz: begin
        ctrl.src_imm = 1'b0;  // compare against rt
        ctrl.wr_en   = 1'b0;
        case (opcode)
          mips_isa_pkg::op_beq:  ctrl.br_kind = core_cfg_pkg::br_eq;
          mips_isa_pkg::op_bne:  ctrl.br_kind = core_cfg_pkg::br_ne;
          mips_isa_pkg::op_blez: ctrl.br_kind = core_cfg_pkg::br_lez;
          default:               ctrl.br_kind = core_cfg_pkg::br_gtz;
        endcase
      end
      mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu: ctrl.alu_op = core_cfg_pkg::alu_add;
      mips_isa_pkg::op_slti:  ctrl.alu_op = core_cfg_pkg::alu_slt;
      mips_isa_pkg::op_sltiu: ctrl.alu_op = core_cfg_pkg::alu_sltu;
      mips_isa_pkg::op_andi, mips_isa_pkg::op_ori, mips_isa_pkg::op_xori,
      mips_isa_pkg::op_lui: begin
        ctrl.imm_signed = 1'b0;  // logic ops zero-extend
        case (opcode)
          mips_isa_pkg::op_andi: ctrl.alu_op = core_cfg_pkg::alu_and;
          mips_isa_pkg::op_ori:  ctrl.alu_op = core_cfg_pkg::alu_or;
          mips_isa_pkg::op_xori: ctrl.alu_op = core_cfg_pkg::alu_xor;
          default:               ctrl.alu_op = core_cfg_pkg::alu_lui;
        endcase
      end
      default: ctrl.illegal = 1'b1;
    endcase
    ctrl.wr_en = ctrl.wr_en && !ctrl.illegal && (ctrl.wr_reg != '0);
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   we,
  input  mips_isa_pkg::reg_idx_t wa,
  input  mips_isa_pkg::reg_idx_t ra1,
  input  mips_isa_pkg::reg_idx_t ra2,
  input  mips_isa_pkg::word_t    wd,
  output mips_isa_pkg::word_t    rd1,
  output mips_isa_pkg::word_t    rd2
);

  mips_isa_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  core_cfg_pkg::alu_op_e  op,
  input  mips_isa_pkg::word_t    a,
  input  mips_isa_pkg::word_t    b,
  input  logic [4:0]             shamt,
  input  core_cfg_pkg::br_kind_e br_kind,
  output mips_isa_pkg::word_t    result,
  output logic                   taken
);

  always_comb begin
    case (op)
      core_cfg_pkg::alu_add:  result = a + b;  // no overflow trap
      core_cfg_pkg::alu_sub:  result = a - b;
      core_cfg_pkg::alu_and:  result = a & b;
      core_cfg_pkg::alu_or:   result = a | b;
      core_cfg_pkg::alu_xor:  result = a ^ b;
      core_cfg_pkg::alu_nor:  result = ~(a | b);
      core_cfg_pkg::alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      core_cfg_pkg::alu_sltu: result = {31'b0, a < b};
      core_cfg_pkg::alu_sll:  result = b << shamt;
      core_cfg_pkg::alu_srl:  result = b >> shamt;
      core_cfg_pkg::alu_sra:  result = $signed(b) >>> shamt;
      core_cfg_pkg::alu_lui:  result = {b[15:0], 16'h0000};
      default:                result = '0;
    endcase
  end

  // branch condition on rs (a) and rt (b)
  always_comb begin
    case (br_kind)
      core_cfg_pkg::br_eq:       taken = (a == b);
      core_cfg_pkg::br_ne:       taken = (a != b);
      core_cfg_pkg::br_lez:      taken = a[31] || (a == '0);
      core_cfg_pkg::br_gtz:      taken = !a[31] && (a != '0);
      core_cfg_pkg::br_ltz:      taken = a[31];
      core_cfg_pkg::br_gez:      taken = !a[31];
      core_cfg_pkg::br_jump,
      core_cfg_pkg::br_jump_reg: taken = 1'b1;
      default:                   taken = 1'b0;
    endcase
  end

endmodule

// ==== source/mips_core.sv ====
`timescale 1ns/1ps

module mips_core (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     run,
  input  logic                     imem_we,
  input  mips_isa_pkg::imem_addr_t imem_addr,
  input  mips_isa_pkg::word_t      imem_data,
  output logic                     retire_valid,
  output core_cfg_pkg::retire_t    retire,
  output string                    trace_str
);

  core_cfg_pkg::ctrl_t    ctrl;
  mips_isa_pkg::word_t    pc;
  mips_isa_pkg::word_t    inst;
  mips_isa_pkg::word_t    rs_val;
  mips_isa_pkg::word_t    rt_val;
  mips_isa_pkg::word_t    op_b;
  mips_isa_pkg::word_t    alu_result;
  mips_isa_pkg::word_t    wr_data;
  mips_isa_pkg::reg_idx_t rs;
  mips_isa_pkg::reg_idx_t rt;
  mips_isa_pkg::imm_t     imm;
  logic [4:0]             shamt;
  logic [4:0]             alu_shamt;
  logic                   taken;

  inst_fetch inst_fetch_inst (
    .clk(clk), .rst(rst), .run(run),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
    .ctrl(ctrl), .taken(taken), .rs_val(rs_val), .imm(imm),
    .pc(pc), .inst(inst)
  );

  inst_decode inst_decode_inst (
    .inst(inst), .ctrl(ctrl), .rs(rs), .rt(rt), .imm(imm), .shamt(shamt)
  );

  reg_file reg_file_inst (
    .clk(clk), .rst(rst), .we(run && ctrl.wr_en), .wa(ctrl.wr_reg),
    .ra1(rs), .ra2(rt), .wd(wr_data), .rd1(rs_val), .rd2(rt_val)
  );

  assign op_b = !ctrl.src_imm  ? rt_val :
                ctrl.imm_signed ? {{16{imm[15]}}, imm} : {16'h0000, imm};
  assign alu_shamt = ctrl.shamt_var ? rs_val[4:0] : shamt;
  assign wr_data   = ctrl.link ? pc + 32'd4 : alu_result;

  alu alu_inst (
    .op(ctrl.alu_op), .a(rs_val), .b(op_b), .shamt(alu_shamt),
    .br_kind(ctrl.br_kind), .result(alu_result), .taken(taken)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= run;
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      retire <= '{pc: pc, inst: inst, wr_en: ctrl.wr_en, wr_reg: ctrl.wr_reg,
                  wr_data: wr_data};
    end
  end

  text_idec text_idec_inst (
    .inst_word(retire.inst), .pc(retire.pc), .inst_str(trace_str)
  );

  // decode must never let a write to r0 reach the retire stream
  a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
    retire_valid |-> !(retire.wr_en && retire.wr_reg == '0));

endmodule

// ==== sim/tb_mips_ref.svh ====
`ifndef TB_MIPS_REF_SVH
`define TB_MIPS_REF_SVH

logic [31:0]         rng_state = 32'd95965;
mips_isa_pkg::word_t prog [mips_isa_pkg::imem_words];
mips_isa_pkg::word_t ref_regs [32] = '{default: '0};
mips_isa_pkg::word_t ref_pc = '0;

localparam mips_isa_pkg::funct_t alu_functs [16] = '{
  mips_isa_pkg::funct_sll,  mips_isa_pkg::funct_srl,  mips_isa_pkg::funct_sra,
  mips_isa_pkg::funct_sllv, mips_isa_pkg::funct_srlv, mips_isa_pkg::funct_srav,
  mips_isa_pkg::funct_add,  mips_isa_pkg::funct_addu, mips_isa_pkg::funct_sub,
  mips_isa_pkg::funct_subu, mips_isa_pkg::funct_and,  mips_isa_pkg::funct_or,
  mips_isa_pkg::funct_xor,  mips_isa_pkg::funct_nor,  mips_isa_pkg::funct_slt,
  mips_isa_pkg::funct_sltu};

localparam mips_isa_pkg::opcode_t imm_ops [8] = '{
  mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu, mips_isa_pkg::op_slti,
  mips_isa_pkg::op_sltiu, mips_isa_pkg::op_andi, mips_isa_pkg::op_ori,
  mips_isa_pkg::op_xori, mips_isa_pkg::op_lui};

function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// s already holds rs, rt, rd, shamt and imm in their field positions
function automatic mips_isa_pkg::word_t gen_inst(input int idx);
  logic [31:0]         r;
  logic [31:0]         s;
  logic [15:0]         off;
  logic [25:0]         tgt;
  int                  kind;
  mips_isa_pkg::word_t w;
  r    = next_rand();
  s    = next_rand();
  kind = int'(r[5:0]);
  off  = {12'h000, r[11:8]};  // forward branches only
  tgt  = {18'd0, 8'(idx + 2 + int'(r[31:28]))};  // forward target that wraps at memory end
  if (kind < 24) begin
    w = {mips_isa_pkg::op_special, s[25:6], alu_functs[r[11:8]]};
  end else if (kind < 46) begin
    w = {imm_ops[r[10:8]], s[25:0]};
  end else begin
    case (kind)
      46: w = {mips_isa_pkg::op_beq, s[25:16], off};
      47: w = {mips_isa_pkg::op_bne, s[25:16], off};
      48: w = {mips_isa_pkg::op_blez, s[25:21], 5'd0, off};
      49: w = {mips_isa_pkg::op_bgtz, s[25:21], 5'd0, off};
      50: w = {mips_isa_pkg::op_regimm, s[25:21], mips_isa_pkg::regimm_bltz, off};
      51: w = {mips_isa_pkg::op_regimm, s[25:21], mips_isa_pkg::regimm_bgez, off};
      52, 53: w = {mips_isa_pkg::op_j, tgt};
      54: w = {mips_isa_pkg::op_jal, tgt};
      55: w = {mips_isa_pkg::op_special, s[25:21], 15'd0, mips_isa_pkg::funct_jr};
      56: w = {mips_isa_pkg::op_special, s[25:21], 5'd0, s[15:11], 5'd0,
               mips_isa_pkg::funct_jalr};
      57: w = {6'h23, s[25:0]};  // lw
      58: w = {mips_isa_pkg::op_special, s[25:16], 10'd0, 6'd24};  // mult
      59: w = {mips_isa_pkg::op_regimm, s[25:21], 5'h10, s[15:0]};  // bltzal
      default: w = {mips_isa_pkg::op_lui, 5'd0, s[20:0]};
    endcase
  end
  return w;
endfunction

// steps the ISA model by one instruction and returns the expected retire
function automatic core_cfg_pkg::retire_t ref_step();
  core_cfg_pkg::retire_t  rec;
  mips_isa_pkg::word_t    w;
  mips_isa_pkg::word_t    a;
  mips_isa_pkg::word_t    b;
  mips_isa_pkg::word_t    pc4;
  mips_isa_pkg::word_t    sext;
  mips_isa_pkg::word_t    nxt;
  mips_isa_pkg::word_t    res;
  mips_isa_pkg::reg_idx_t dst;
  logic                   wr;
  logic                   take;
  w    = prog[ref_pc[9:2]];
  a    = ref_regs[w[25:21]];
  b    = ref_regs[w[20:16]];
  pc4  = ref_pc + 32'd4;
  sext = {{16{w[15]}}, w[15:0]};
  nxt  = pc4;
  dst  = w[20:16];
  res  = '0;
  wr   = 1'b0;
  take = 1'b0;
  case (w[31:26])
    mips_isa_pkg::op_special: begin
      dst = w[15:11];
      wr  = 1'b1;
      case (w[5:0])
        mips_isa_pkg::funct_sll:  res = b << w[10:6];
        mips_isa_pkg::funct_srl:  res = b >> w[10:6];
        mips_isa_pkg::funct_sra:  res = $signed(b) >>> w[10:6];
        mips_isa_pkg::funct_sllv: res = b << a[4:0];
        mips_isa_pkg::funct_srlv: res = b >> a[4:0];
        mips_isa_pkg::funct_srav: res = $signed(b) >>> a[4:0];
        mips_isa_pkg::funct_jr: begin
          wr  = 1'b0;
          nxt = a;
        end
        mips_isa_pkg::funct_jalr: begin
          res = pc4;
          nxt = a;
        end
        mips_isa_pkg::funct_add, mips_isa_pkg::funct_addu: res = a + b;
        mips_isa_pkg::funct_sub, mips_isa_pkg::funct_subu: res = a - b;
        mips_isa_pkg::funct_and:  res = a & b;
        mips_isa_pkg::funct_or:   res = a | b;
        mips_isa_pkg::funct_xor:  res = a ^ b;
        mips_isa_pkg::funct_nor:  res = ~(a | b);
        mips_isa_pkg::funct_slt:  res = {31'b0, $signed(a) < $signed(b)};
        mips_isa_pkg::funct_sltu: res = {31'b0, a < b};
        default:                  wr = 1'b0;
      endcase
    end
    mips_isa_pkg::op_regimm: take = (w[20:16] == mips_isa_pkg::regimm_bltz && a[31]) ||
                                    (w[20:16] == mips_isa_pkg::regimm_bgez && !a[31]);
    mips_isa_pkg::op_j: nxt = {pc4[31:28], w[25:0], 2'b00};
    mips_isa_pkg::op_jal: begin
      dst = 5'd31;
      wr  = 1'b1;
      res = pc4;
      nxt = {pc4[31:28], w[25:0], 2'b00};
    end
    mips_isa_pkg::op_beq:  take = (a == b);
    mips_isa_pkg::op_bne:  take = (a != b);
    mips_isa_pkg::op_blez: take = a[31] || (a == '0);
    mips_isa_pkg::op_bgtz: take = !a[31] && (a != '0);
    mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu: begin
      wr  = 1'b1;
      res = a + sext;
    end
    mips_isa_pkg::op_slti, mips_isa_pkg::op_sltiu, mips_isa_pkg::op_andi,
    mips_isa_pkg::op_ori, mips_isa_pkg::op_xori, mips_isa_pkg::op_lui: begin
      wr = 1'b1;
      case (w[31:26])
        mips_isa_pkg::op_slti:  res = {31'b0, $signed(a) < $signed(sext)};
        mips_isa_pkg::op_sltiu: res = {31'b0, a < sext};
        mips_isa_pkg::op_andi:  res = a & {16'h0000, w[15:0]};
        mips_isa_pkg::op_ori:   res = a | {16'h0000, w[15:0]};
        mips_isa_pkg::op_xori:  res = a ^ {16'h0000, w[15:0]};
        default:                res = {w[15:0], 16'h0000};
      endcase
    end
    default: ;  // unsupported words retire as a no-op
  endcase
  if (take) begin
    nxt = pc4 + {sext[29:0], 2'b00};
  end
  wr = wr && (dst != 5'd0);  // r0 stays zero
  if (wr) begin
    ref_regs[dst] = res;
  end
  rec = '{pc: ref_pc, inst: w, wr_en: wr, wr_reg: dst, wr_data: res};
  ref_pc = nxt;
  return rec;
endfunction

// expected assembler mnemonic of a supported word
function automatic string mnemonic_of(input mips_isa_pkg::word_t w);
  string m;
  m = "";
  case (w[31:26])
    mips_isa_pkg::op_special: begin
      case (w[5:0])
        mips_isa_pkg::funct_sll:  m = "sll";
        mips_isa_pkg::funct_srl:  m = "srl";
        mips_isa_pkg::funct_sra:  m = "sra";
        mips_isa_pkg::funct_sllv: m = "sllv";
        mips_isa_pkg::funct_srlv: m = "srlv";
        mips_isa_pkg::funct_srav: m = "srav";
        mips_isa_pkg::funct_jr:   m = "jr";
        mips_isa_pkg::funct_jalr: m = "jalr";
        mips_isa_pkg::funct_add:  m = "add";
        mips_isa_pkg::funct_addu: m = "addu";
        mips_isa_pkg::funct_sub:  m = "sub";
        mips_isa_pkg::funct_subu: m = "subu";
        mips_isa_pkg::funct_and:  m = "and";
        mips_isa_pkg::funct_or:   m = "or";
        mips_isa_pkg::funct_xor:  m = "xor";
        mips_isa_pkg::funct_nor:  m = "nor";
        mips_isa_pkg::funct_slt:  m = "slt";
        mips_isa_pkg::funct_sltu: m = "sltu";
        default:                  m = "";
      endcase
    end
    mips_isa_pkg::op_regimm: begin
      case (w[20:16])
        mips_isa_pkg::regimm_bltz: m = "bltz";
        mips_isa_pkg::regimm_bgez: m = "bgez";
        default:                   m = "";
      endcase
    end
    mips_isa_pkg::op_j:     m = "j";
    mips_isa_pkg::op_jal:   m = "jal";
    mips_isa_pkg::op_beq:   m = "beq";
    mips_isa_pkg::op_bne:   m = "bne";
    mips_isa_pkg::op_blez:  m = "blez";
    mips_isa_pkg::op_bgtz:  m = "bgtz";
    mips_isa_pkg::op_addi:  m = "addi";
    mips_isa_pkg::op_addiu: m = "addiu";
    mips_isa_pkg::op_slti:  m = "slti";
    mips_isa_pkg::op_sltiu: m = "sltiu";
    mips_isa_pkg::op_andi:  m = "andi";
    mips_isa_pkg::op_ori:   m = "ori";
    mips_isa_pkg::op_xori:  m = "xori";
    mips_isa_pkg::op_lui:   m = "lui";
    default:                m = "";
  endcase
  return m;
endfunction

`endif

// ==== sim/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core;

  localparam int num_retires    = 2000;
  localparam int pause_at       = 1000;
  localparam int pause_cycles   = 4;
  localparam int timeout_cycles = mips_isa_pkg::imem_words + num_retires + 100;

  logic                     clk;
  logic                     rst;
  logic                     run;
  logic                     imem_we;
  mips_isa_pkg::imem_addr_t imem_addr;
  mips_isa_pkg::word_t      imem_data;
  logic                     retire_valid;
  core_cfg_pkg::retire_t    retire;
  string                    trace_str;

  int                    n_retired = 0;
  int                    n_cycles  = 0;
  logic                  prev_rst  = 1'b1;
  logic                  prev_run  = 1'b0;
  logic                  exp_valid;
  core_cfg_pkg::retire_t exp_rec;

  `include "tb_mips_ref.svh"

  mips_core mips_core_inst (
    .clk(clk), .rst(rst), .run(run),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
    .retire_valid(retire_valid), .retire(retire), .trace_str(trace_str)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_valid(input logic exp, input logic got);
    if (got !== exp) begin
      $display("ERR retire_valid exp 0x%0h got 0x%0h", exp, got);
      $display("test failed");
      $fatal(1, "retire_valid mismatch");
    end
  endtask

  task automatic check_retire(input core_cfg_pkg::retire_t exp,
                              input core_cfg_pkg::retire_t got);
    logic bad;
    bad = 1'b0;
    if (got.pc !== exp.pc) begin
      $display("ERR retire.pc exp 0x%08h got 0x%08h", exp.pc, got.pc);
      bad = 1'b1;
    end
    if (got.inst !== exp.inst) begin
      $display("ERR retire.inst exp 0x%08h got 0x%08h", exp.inst, got.inst);
      bad = 1'b1;
    end
    if (got.wr_en !== exp.wr_en) begin
      $display("ERR retire.wr_en exp 0x%0h got 0x%0h", exp.wr_en, got.wr_en);
      bad = 1'b1;
    end
    if (exp.wr_en && got.wr_reg !== exp.wr_reg) begin  // dest only means something on a write
      $display("ERR retire.wr_reg exp 0x%02h got 0x%02h", exp.wr_reg, got.wr_reg);
      bad = 1'b1;
    end
    if (exp.wr_en && got.wr_data !== exp.wr_data) begin
      $display("ERR retire.wr_data exp 0x%08h got 0x%08h", exp.wr_data, got.wr_data);
      bad = 1'b1;
    end
    if (bad) begin
      $display("retire %0d: %s", n_retired, trace_str);
      $display("test failed");
      $fatal(1, "retire record mismatch");
    end
  endtask

  // trace text must open with the mnemonic and a space
  task automatic check_trace(input mips_isa_pkg::word_t inst, input string exp_mn,
                             input string got);
    string head;
    head = got.substr(0, exp_mn.len());
    if (exp_mn.len() > 0 && head != {exp_mn, " "}) begin
      $display("ERR trace_str inst 0x%08h exp \"%s ...\" got \"%s\"", inst, exp_mn, got);
      $display("test failed");
      $fatal(1, "trace text mismatch");
    end
  endtask

  initial begin
    rst       <= 1'b1;
    run       <= 1'b0;
    imem_we   <= 1'b0;
    imem_addr <= '0;
    imem_data <= '0;
    for (int i = 0; i < mips_isa_pkg::imem_words; i++) begin
      prog[i] = gen_inst(i);
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < mips_isa_pkg::imem_words; i++) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= mips_isa_pkg::imem_addr_t'(i);
      imem_data <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    run     <= 1'b1;
    while (n_retired < pause_at) @(posedge clk);
    run <= 1'b0;  // stall mid-program
    repeat (pause_cycles) @(posedge clk);
    run <= 1'b1;
  end

  // outputs sampled at the falling edge
  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      exp_valid = !prev_rst && prev_run;  // levels seen at the last rising edge
      prev_rst  = rst;
      prev_run  = run;
      check_valid(exp_valid, retire_valid);
      if (retire_valid) begin
        exp_rec = ref_step();
        check_retire(exp_rec, retire);
        check_trace(exp_rec.inst, mnemonic_of(exp_rec.inst), trace_str);
        n_retired++;
        if (n_retired == num_retires) begin
          $display("test passed");
          $finish;
        end
      end
    end
  end

  always @(posedge clk) begin
    n_cycles <= n_cycles + 1;
    if (n_cycles >= timeout_cycles) begin
      $display("test failed");
      $fatal(1, "timeout: retire stream stalled");
    end
  end

endmodule

// ==== sim.f ====
+incdir+sim
source/mips_isa_pkg.sv
source/core_cfg_pkg.sv
source/text_idec.sv
source/inst_fetch.sv
source/inst_decode.sv
source/reg_file.sv
source/alu.sv
source/mips_core.sv
sim/tb_mips_core.sv
